//--- floo_reduction_alu.f
hdl/floo_red_pkg.sv
hdl/floo_red_spill_register.sv
hdl/floo_red_alu_core.sv
hdl/floo_reduction_alu.sv
verification/floo_reduction_alu_sva.sv
verification/floo_reduction_alu_tb.sv

//--- Makefile
TOP := floo_reduction_alu_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f floo_reduction_alu.f
	@out="$$(./obj_dir/V$(TOP))"; status=$$?; echo "$$out"; \
	if [ $$status -eq 0 ] && echo "$$out" | grep -qx "Finished with no errors"; then \
	  echo "Simulation passed"; \
	else \
	  echo "Simulation failed"; \
	  exit 1; \
	fi

clean:
	rm -rf obj_dir

//--- verification/floo_reduction_alu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module floo_reduction_alu_tb;

  localparam int unsigned N_DIRECTED = 16;
  localparam int unsigned N_RANDOM   = 200;
  localparam int unsigned MAX_CYCLES = (N_DIRECTED + N_RANDOM) * 4 + 200;

  // One directed row, request and expected response
  typedef struct packed {
    floo_red_pkg::red_req_t  req;
    floo_red_pkg::red_resp_t exp;
  } vec_t;

  // DUT ports
  logic                    clk_i = 1'b0;
  logic                    rst_i;
  logic                    flush_i;
  floo_red_pkg::red_req_t  req_i;
  logic                    req_valid_i;
  logic                    req_ready_o;
  floo_red_pkg::red_resp_t resp_o;
  logic                    resp_valid_o;
  logic                    resp_ready_i;

  // Scoreboard
  floo_red_pkg::red_resp_t exp_q[$];
  vec_t                    vectors[$];
  int                      err_count;
  int                      n_checks;
  int                      errs_mark;
  int                      checks_mark;
  int unsigned             cycle_count = 0;
  logic                    req_taken;
  // Sink behavior: 0 ready, 1 stalled, 2 random
  int                      ready_mode;
  logic [31:0]             req_rnd;
  logic [31:0]             stall_rnd;
  floo_red_pkg::red_req_t  rnd_req;

  floo_reduction_alu uut (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .flush_i      (flush_i),
    .req_i        (req_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .resp_o       (resp_o),
    .resp_valid_o (resp_valid_o),
    .resp_ready_i (resp_ready_i)
  );

  always #5 clk_i = ~clk_i;

  // Watchdog
  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == MAX_CYCLES) begin
      $display("ERROR: run hung, still going after %0d cycles", MAX_CYCLES);
      $display("Finished with errors");
      $finish;
    end
  end

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Reference model, low words only, result sign extended from bit 31
  function automatic floo_red_pkg::red_resp_t predict(input floo_red_pkg::red_req_t r);
    floo_red_pkg::red_resp_t p;
    logic [31:0]             a;
    logic [31:0]             b;
    logic [31:0]             res;
    a = r.op1[31:0];
    b = r.op2[31:0];
    case (r.op_type)
      floo_red_pkg::A_Mul:   res = a * b;
      floo_red_pkg::A_Min_S: res = ($signed(a) < $signed(b)) ? a : b;
      floo_red_pkg::A_Min_U: res = (a < b) ? a : b;
      floo_red_pkg::A_Max_S: res = ($signed(a) < $signed(b)) ? b : a;
      floo_red_pkg::A_Max_U: res = (a < b) ? b : a;
      // Unused codes add
      default:               res = a + b;
    endcase
    p.data = {{32{res[31]}}, res};
    p.zero = (res == 32'd0);
    return p;
  endfunction

  function automatic void add_row(input floo_red_pkg::reduction_op_e op,
                                  input logic [63:0] a, input logic [63:0] b,
                                  input logic [63:0] d, input logic z);
    vec_t v;
    v.req.op1     = a;
    v.req.op2     = b;
    v.req.op_type = op;
    v.exp.data    = d;
    v.exp.zero    = z;
    vectors.push_back(v);
  endfunction

  task automatic check_bit(input string name, input logic exp_v, input logic act_v);
    n_checks++;
    if (act_v !== exp_v) begin
      $display("FAIL t=%0t %s expected %b got %b", $time, name, exp_v, act_v);
      err_count++;
    end
  endtask

  task automatic check_resp(input floo_red_pkg::red_resp_t exp_v,
                            input floo_red_pkg::red_resp_t act_v);
    n_checks++;
    if (act_v.data !== exp_v.data) begin
      $display("FAIL t=%0t resp_o.data expected %h got %h", $time, exp_v.data, act_v.data);
      err_count++;
    end
    if (act_v.zero !== exp_v.zero) begin
      $display("FAIL t=%0t resp_o.zero expected %b got %b", $time, exp_v.zero, act_v.zero);
      err_count++;
    end
  endtask

  // One clock edge, with the response monitor and the sink's ready level
  task automatic tick();
    floo_red_pkg::red_resp_t exp_r;
    @(posedge clk_i);
    if (!rst_i && resp_valid_o && resp_ready_i) begin
      if (exp_q.size() == 0) begin
        $display("ERROR at %0t: response arrived with nothing outstanding", $time);
        err_count++;
      end else begin
        exp_r = exp_q.pop_front();
        check_resp(exp_r, resp_o);
      end
    end
    // A request offered during flush is dropped
    req_taken = !rst_i && !flush_i && req_valid_i && req_ready_o;
    stall_rnd = lcg_step(stall_rnd);
    case (ready_mode)
      0:       resp_ready_i <= 1'b1;
      1:       resp_ready_i <= 1'b0;
      default: resp_ready_i <= (stall_rnd[17:16] != 2'b00);
    endcase
  endtask

  task automatic send_req(input floo_red_pkg::red_req_t r, input floo_red_pkg::red_resp_t e);
    req_i       <= r;
    req_valid_i <= 1'b1;
    do begin
      tick();
    end while (!req_taken);
    exp_q.push_back(e);
  endtask

  // Let every outstanding result leave, then expect an idle output
  task automatic drain();
    req_valid_i <= 1'b0;
    ready_mode = 0;
    while (exp_q.size() != 0) begin
      tick();
    end
    tick();
    check_bit("resp_valid_o", 1'b0, resp_valid_o);
  endtask

  task automatic end_test(input string name);
    $display("Test %0s done: %0d checks, %0d errors", name, n_checks - checks_mark,
             err_count - errs_mark);
    checks_mark = n_checks;
    errs_mark   = err_count;
  endtask

  // --------------------------------------------------
  // Sequence
  // --------------------------------------------------

  initial begin : main_seq
    err_count    = 0;
    n_checks     = 0;
    errs_mark    = 0;
    checks_mark  = 0;
    ready_mode   = 0;
    req_rnd      = 32'h60ec_97f7;
    stall_rnd    = lcg_step(lcg_step(32'h60ec_97f7));
    rst_i        <= 1'b1;
    flush_i      <= 1'b0;
    req_i        <= '0;
    req_valid_i  <= 1'b0;
    resp_ready_i <= 1'b0;

    // Overflow, negative products, mixed signs, zero after truncation, unused codes
    add_row(floo_red_pkg::A_Add, 64'h7fff_ffff, 64'h1, 64'hffff_ffff_8000_0000, 1'b0);
    add_row(floo_red_pkg::A_Add, 64'h5555_0000_ffff_ffff, 64'h1_0000_0001, 64'h0, 1'b1);
    add_row(floo_red_pkg::A_Add, 64'h1_0000_0005, 64'habcd_0000_0000_0003, 64'h8, 1'b0);
    add_row(floo_red_pkg::A_Mul, 64'h1_0000, 64'h8000, 64'hffff_ffff_8000_0000, 1'b0);
    add_row(floo_red_pkg::A_Mul, 64'hffff_ffff, 64'h5, 64'hffff_ffff_ffff_fffb, 1'b0);
    add_row(floo_red_pkg::A_Mul, 64'hdead_beef_0000_0000, 64'h1234, 64'h0, 1'b1);
    add_row(floo_red_pkg::A_Mul, 64'h1234_5678, 64'h10, 64'h2345_6780, 1'b0);
    add_row(floo_red_pkg::A_Min_S, 64'hffff_fff0, 64'h10, 64'hffff_ffff_ffff_fff0, 1'b0);
    add_row(floo_red_pkg::A_Min_U, 64'hffff_fff0, 64'h10, 64'h10, 1'b0);
    add_row(floo_red_pkg::A_Max_S, 64'hffff_fff0, 64'h10, 64'h10, 1'b0);
    add_row(floo_red_pkg::A_Max_U, 64'hffff_fff0, 64'h10, 64'hffff_ffff_ffff_fff0, 1'b0);
    add_row(floo_red_pkg::A_Min_S, 64'h8000_0000, 64'h7fff_ffff, 64'hffff_ffff_8000_0000, 1'b0);
    add_row(floo_red_pkg::A_Max_U, 64'h8000_0000, 64'h7fff_ffff, 64'hffff_ffff_8000_0000, 1'b0);
    add_row(floo_red_pkg::A_Max_S, 64'h0123_0000_0000_0000, 64'h0, 64'h0, 1'b1);
    add_row(floo_red_pkg::reduction_op_e'(3'd7), 64'h2, 64'h3, 64'h5, 1'b0);
    add_row(floo_red_pkg::reduction_op_e'(3'd6), 64'h7fff_ffff, 64'h7fff_ffff,
            64'hffff_ffff_ffff_fffe, 1'b0);

    repeat (4) tick();
    rst_i <= 1'b0;
    tick();
    check_bit("resp_valid_o", 1'b0, resp_valid_o);
    check_bit("req_ready_o", 1'b1, req_ready_o);
    end_test("reset");

    // Each row answers one cycle after its accepting edge
    foreach (vectors[i]) begin
      send_req(vectors[i].req, vectors[i].exp);
      req_valid_i <= 1'b0;
      tick();
      check_bit("resp_valid_o", 1'b1, resp_valid_o);
    end
    drain();
    end_test("directed");

    ready_mode = 2;
    for (int i = 0; i < N_RANDOM; i++) begin
      req_rnd = lcg_step(req_rnd);
      rnd_req.op1[63:32] = req_rnd;
      req_rnd = lcg_step(req_rnd);
      rnd_req.op1[31:0] = req_rnd;
      req_rnd = lcg_step(req_rnd);
      rnd_req.op2[63:32] = req_rnd;
      req_rnd = lcg_step(req_rnd);
      rnd_req.op2[31:0] = req_rnd;
      req_rnd = lcg_step(req_rnd);
      rnd_req.op_type = floo_red_pkg::reduction_op_e'(req_rnd[30:28]);
      // Now and then a low word that cancels, for zero sums
      if (req_rnd[21:20] == 2'b00) begin
        rnd_req.op2[31:0] = -rnd_req.op1[31:0];
      end
      send_req(rnd_req, predict(rnd_req));
    end
    drain();
    end_test("random");

    // Two results fill the output buffer
    ready_mode = 1;
    tick();
    send_req(vectors[0].req, vectors[0].exp);
    send_req(vectors[1].req, vectors[1].exp);
    req_valid_i <= 1'b0;
    tick();
    check_bit("req_ready_o", 1'b0, req_ready_o);
    check_bit("resp_valid_o", 1'b1, resp_valid_o);
    drain();
    end_test("backpressure");

    ready_mode = 1;
    tick();
    send_req(vectors[3].req, vectors[3].exp);
    send_req(vectors[4].req, vectors[4].exp);
    req_valid_i <= 1'b0;
    tick();
    check_bit("resp_valid_o", 1'b1, resp_valid_o);
    flush_i <= 1'b1;
    tick();
    flush_i <= 1'b0;
    exp_q.delete();
    tick();
    check_bit("resp_valid_o", 1'b0, resp_valid_o);
    ready_mode = 0;
    for (int i = 5; i < 9; i++) begin
      send_req(vectors[i].req, vectors[i].exp);
    end
    drain();
    end_test("flush");

    $display("Totals: %0d checks, %0d errors, %0d cycles", n_checks, err_count, cycle_count);
    if (err_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/floo_reduction_alu_sva.sv
`timescale 1ns/1ps
`default_nettype none

module floo_reduction_alu_sva (
  input wire logic                    clk_i,
  input wire logic                    rst_i,
  input wire logic                    flush_i,
  input wire logic                    req_ready_o,
  input wire floo_red_pkg::red_resp_t resp_o,
  input wire logic                    resp_valid_o,
  input wire logic                    resp_ready_i
);

  // Output buffer is empty one edge after reset or flush
  a_empty_after_clear: assert property (
    @(posedge clk_i) (rst_i || flush_i) |=> !resp_valid_o
  ) else $error("resp_valid_o high after reset or flush");

  // A stalled response keeps its valid and its payload
  // Reset or flush on the stalling edge empties the buffer instead
  a_stall_stable: assert property (
    @(posedge clk_i)
    (!rst_i && !flush_i && resp_valid_o && !resp_ready_i) |=>
      (resp_valid_o && $stable(resp_o))
  ) else $error("response changed while stalled");

  // Unit takes requests on the first cycle out of reset
  a_ready_after_reset: assert property (
    @(posedge clk_i) $fell(rst_i) |-> req_ready_o
  ) else $error("req_ready_o low on the first cycle after reset");

endmodule

bind floo_reduction_alu floo_reduction_alu_sva i_sva (
  .clk_i        (clk_i),
  .rst_i        (rst_i),
  .flush_i      (flush_i),
  .req_ready_o  (req_ready_o),
  .resp_o       (resp_o),
  .resp_valid_o (resp_valid_o),
  .resp_ready_i (resp_ready_i)
);

`default_nettype wire

//--- hdl/floo_reduction_alu.sv
`timescale 1ns/1ps
`default_nettype none

module floo_reduction_alu (
  input  wire logic                   clk_i,
  input  wire logic                   rst_i,
  input  wire logic                   flush_i,
  // Requests from the network
  input  wire floo_red_pkg::red_req_t req_i,
  input  wire logic                   req_valid_i,
  output logic                        req_ready_o,
  // Responses towards the network
  output floo_red_pkg::red_resp_t     resp_o,
  output logic                        resp_valid_o,
  input  wire logic                   resp_ready_i
);

  // Decoded request and raw core result
  floo_red_pkg::alu_in_t  alu_in;
  floo_red_pkg::alu_out_t alu_out;

  // --------------------------------------------------
  // Opcode decoder
  // --------------------------------------------------

  always_comb begin : decode
    alu_in.operands[0] = req_i.op1;
    alu_in.operands[1] = req_i.op2;
    // Unused codes end up as a signed add
    alu_in.op  = floo_red_pkg::ADD;
    alu_in.fmt = floo_red_pkg::INT32;
    case (req_i.op_type)
      floo_red_pkg::A_Mul:   alu_in.op = floo_red_pkg::MUL;
      floo_red_pkg::A_Min_S: alu_in.op = floo_red_pkg::MIN;
      floo_red_pkg::A_Max_S: alu_in.op = floo_red_pkg::MAX;
      floo_red_pkg::A_Min_U: begin
        alu_in.op  = floo_red_pkg::MIN;
        alu_in.fmt = floo_red_pkg::UINT32;
      end
      floo_red_pkg::A_Max_U: begin
        alu_in.op  = floo_red_pkg::MAX;
        alu_in.fmt = floo_red_pkg::UINT32;
      end
      default: ;
    endcase
  end

  // Registered result path, unregistered request path
  floo_red_alu_core #(
    .CutInput  (1'b0),
    .CutOutput (1'b1)
  ) i_core (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .flush_i     (flush_i),
    .in_i        (alu_in),
    .in_valid_i  (req_valid_i),
    .in_ready_o  (req_ready_o),
    .out_o       (alu_out),
    .out_valid_o (resp_valid_o),
    .out_ready_i (resp_ready_i)
  );

  // Repack into the network response
  assign resp_o.data = alu_out.result;
  assign resp_o.zero = alu_out.status.is_zero;

endmodule

`default_nettype wire

//--- hdl/floo_red_alu_core.sv
`timescale 1ns/1ps
`default_nettype none

module floo_red_alu_core #(
  parameter bit CutInput  = 1'b1,
  parameter bit CutOutput = 1'b1
) (
  input  wire logic                  clk_i,
  input  wire logic                  rst_i,
  input  wire logic                  flush_i,
  // Request side
  input  wire floo_red_pkg::alu_in_t in_i,
  input  wire logic                  in_valid_i,
  output logic                       in_ready_o,
  // Response side
  output floo_red_pkg::alu_out_t     out_o,
  output logic                       out_valid_o,
  input  wire logic                  out_ready_i
);

  // Request after the input cut
  floo_red_pkg::alu_in_t in_q;
  logic                  in_valid_q;
  logic                  in_ready_q;

  // Result ahead of the output cut
  floo_red_pkg::alu_out_t out_d;
  logic                   out_valid_d;
  logic                   out_ready_d;

  // Truncated operands and partial results
  logic [floo_red_pkg::NUM_OPERANDS-1:0][floo_red_pkg::OPERAND_WIDTH-1:0] operands_32;
  logic [floo_red_pkg::OPERAND_WIDTH-1:0] add_res;
  logic [floo_red_pkg::OPERAND_WIDTH-1:0] mul_res;
  logic [floo_red_pkg::OPERAND_WIDTH-1:0] min_res;
  logic [floo_red_pkg::OPERAND_WIDTH-1:0] max_res;
  logic [floo_red_pkg::OPERAND_WIDTH-1:0] res_32;

  // --------------------------------------------------
  // Input cut
  // --------------------------------------------------

  if (CutInput) begin : gen_in_cut
    floo_red_spill_register #(
      .T (floo_red_pkg::alu_in_t)
    ) i_in_cut (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .flush_i (flush_i),
      .valid_i (in_valid_i),
      .ready_o (in_ready_o),
      .data_i  (in_i),
      .valid_o (in_valid_q),
      .ready_i (in_ready_q),
      .data_o  (in_q)
    );
  end else begin : gen_in_bypass
    // Ready goes straight back upstream
    assign in_q       = in_i;
    assign in_valid_q = in_valid_i;
    assign in_ready_o = in_ready_q;
  end

  // --------------------------------------------------
  // Datapath
  // --------------------------------------------------

  // Only the low word of each operand takes part
  for (genvar i = 0; i < floo_red_pkg::NUM_OPERANDS; i++) begin : gen_trunc
    assign operands_32[i] = in_q.operands[i][floo_red_pkg::OPERAND_WIDTH-1:0];
  end

  // Adder, wraps on overflow
  assign add_res = operands_32[0] + operands_32[1];

  // Shift and add multiplier
  // Keeps only the low word of the product
  always_comb begin : mul_path
    mul_res = '0;
    for (int i = 0; i < floo_red_pkg::OPERAND_WIDTH; i++) begin
      if (operands_32[0][i]) begin
        mul_res = mul_res + (operands_32[1] << i);
      end
    end
  end

  // One 33 bit signed compare covers both formats
  always_comb begin : minmax_path
    logic                                     sign_en;
    logic signed [floo_red_pkg::OPERAND_WIDTH:0] a_ext;
    logic signed [floo_red_pkg::OPERAND_WIDTH:0] b_ext;

    // Extend with the sign bit for INT32 and with zero for UINT32
    sign_en = (in_q.fmt == floo_red_pkg::INT32);
    a_ext = {sign_en & operands_32[0][floo_red_pkg::OPERAND_WIDTH-1], operands_32[0]};
    b_ext = {sign_en & operands_32[1][floo_red_pkg::OPERAND_WIDTH-1], operands_32[1]};

    if (a_ext > b_ext) begin
      max_res = operands_32[0];
      min_res = operands_32[1];
    end else begin
      max_res = operands_32[1];
      min_res = operands_32[0];
    end
  end

  // Select by the operation that travelled with the operands
  always_comb begin : result_mux
    unique case (in_q.op)
      floo_red_pkg::ADD: res_32 = add_res;
      floo_red_pkg::MUL: res_32 = mul_res;
      floo_red_pkg::MIN: res_32 = min_res;
      floo_red_pkg::MAX: res_32 = max_res;
      default:           res_32 = add_res;
    endcase
  end

  // Sign extend to the full data width
  assign out_d.result = {
    {(floo_red_pkg::DATA_WIDTH - floo_red_pkg::OPERAND_WIDTH){res_32[floo_red_pkg::OPERAND_WIDTH-1]}},
    res_32
  };
  // Zero flag looks at the computed word only
  assign out_d.status.is_zero = ~(|res_32);

  // Datapath is combinational, so the handshake passes through
  assign out_valid_d = in_valid_q;
  assign in_ready_q  = out_ready_d;

  // --------------------------------------------------
  // Output cut
  // --------------------------------------------------

  if (CutOutput) begin : gen_out_cut
    floo_red_spill_register #(
      .T (floo_red_pkg::alu_out_t)
    ) i_out_cut (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .flush_i (flush_i),
      .valid_i (out_valid_d),
      .ready_o (out_ready_d),
      .data_i  (out_d),
      .valid_o (out_valid_o),
      .ready_i (out_ready_i),
      .data_o  (out_o)
    );
  end else begin : gen_out_bypass
    assign out_o       = out_d;
    assign out_valid_o = out_valid_d;
    assign out_ready_d = out_ready_i;
  end

endmodule

`default_nettype wire

//--- hdl/floo_red_spill_register.sv
`timescale 1ns/1ps
`default_nettype none

module floo_red_spill_register #(
  parameter type T = logic
) (
  input  wire logic clk_i,
  input  wire logic rst_i,
  input  wire logic flush_i,
  // Upstream side
  input  wire logic valid_i,
  output logic      ready_o,
  input  wire T     data_i,
  // Downstream side
  output logic      valid_o,
  input  wire logic ready_i,
  output T          data_o
);

  // --------------------------------------------------
  // Storage
  // --------------------------------------------------

  // Slot A takes every new item
  logic a_full_q;
  T     a_data_q;
  // Slot B catches the item in A when downstream stalls
  logic b_full_q;
  T     b_data_q;

  // Slot movements this cycle
  logic a_fill;
  logic a_drain;
  logic b_fill;
  logic b_drain;

  // Accept while at least one slot is free
  assign ready_o = ~a_full_q | ~b_full_q;

  // New item enters A
  assign a_fill = valid_i & ready_o;
  // A empties whenever B is free
  // Its item either leaves downstream or moves into B
  assign a_drain = a_full_q & ~b_full_q;

  // A leaving item goes into B only when downstream refuses it
  assign b_fill = a_drain & ~ready_i;
  // B holds the older item and is served first
  assign b_drain = b_full_q & ready_i;

  // --------------------------------------------------
  // Control flags
  // --------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      // Flush also drops whatever is offered this cycle
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill || a_drain) begin
        a_full_q <= a_fill;
      end
      if (b_fill || b_drain) begin
        b_full_q <= b_fill;
      end
    end
  end

  // --------------------------------------------------
  // Payload registers
  // --------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= data_i;
    end
    // B samples the old contents of A on the same edge
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  // Output side
  assign valid_o = a_full_q | b_full_q;
  assign data_o  = b_full_q ? b_data_q : a_data_q;

endmodule

`default_nettype wire

//--- hdl/floo_red_pkg.sv
`default_nettype none

package floo_red_pkg;

  // --------------------------------------------------
  // Widths
  // --------------------------------------------------

  // Operand and result width at the network side
  localparam int unsigned DATA_WIDTH = 64;
  // Width the ALU actually computes in
  localparam int unsigned OPERAND_WIDTH = 32;
  // Operands carried per request
  localparam int unsigned NUM_OPERANDS = 2;

  // --------------------------------------------------
  // Encodings
  // --------------------------------------------------

  // Network reduction opcode
  // Codes 6 and 7 are unused and fall back to a signed add
  typedef enum logic [2:0] {
    A_Add   = 3'd0,
    A_Mul   = 3'd1,
    A_Min_S = 3'd2,
    A_Min_U = 3'd3,
    A_Max_S = 3'd4,
    A_Max_U = 3'd5
  } reduction_op_e;

  // Operation executed by the ALU core
  typedef enum logic [1:0] {
    ADD = 2'd0,
    MUL = 2'd1,
    MIN = 2'd2,
    MAX = 2'd3
  } alu_operation_e;

  // Integer format
  // Signedness only matters for min and max
  typedef enum logic {
    INT32  = 1'b0,
    UINT32 = 1'b1
  } alu_int_format_e;

  // --------------------------------------------------
  // Payloads
  // --------------------------------------------------

  // Status flags next to the result
  typedef struct packed {
    logic is_zero;
  } alu_status_t;

  // Request at the top level ports
  typedef struct packed {
    logic [DATA_WIDTH-1:0] op1;
    logic [DATA_WIDTH-1:0] op2;
    reduction_op_e         op_type;
  } red_req_t;

  // Response at the top level ports
  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic                  zero;
  } red_resp_t;

  // Decoded request into the core, also the input cut payload
  typedef struct packed {
    logic [NUM_OPERANDS-1:0][DATA_WIDTH-1:0] operands;
    alu_operation_e                          op;
    alu_int_format_e                         fmt;
  } alu_in_t;

  // Core result, also the output cut payload
  typedef struct packed {
    logic [DATA_WIDTH-1:0] result;
    alu_status_t           status;
  } alu_out_t;

endpackage

`default_nettype wire
